//--- source/hci_pkg.sv
// Bus widths, register offsets and the bus and queue entry types
// shared by the HCI queue block
package hci_pkg;

  parameter int unsigned CsrDataWidth = 32;
  parameter int unsigned CsrAddrWidth = 12;
  parameter int unsigned ThldWidth    = 8;

  typedef logic [CsrAddrWidth-1:0] csr_addr_t;
  typedef logic [CsrDataWidth-1:0] csr_data_t;
  typedef logic [ThldWidth-1:0]    thld_t;

  // Byte offsets on the CPU bus
  localparam csr_addr_t RegResetCtrl    = csr_addr_t'('h00);
  localparam csr_addr_t RegQueueThld    = csr_addr_t'('h04);
  localparam csr_addr_t RegCommandPort  = csr_addr_t'('h08);
  localparam csr_addr_t RegResponsePort = csr_addr_t'('h0C);
  localparam csr_addr_t RegQueueStatus  = csr_addr_t'('h10);

  // Request is held by the host until accepted
  typedef struct packed {
    logic      req;
    logic      is_wr;
    csr_addr_t addr;
    csr_data_t wdata;
  } csr_req_t;

  typedef struct packed {
    logic      stall_wr;
    logic      rd_ack;
    logic      wr_ack;
    logic      err;     // Valid with either ack
    csr_data_t rd_data;
  } csr_rsp_t;

  // First written dword sits in bits 31:0
  typedef struct packed {
    csr_data_t hi;
    csr_data_t lo;
  } cmd_entry_t;

  typedef logic [CsrDataWidth-1:0] resp_entry_t;

endpackage : hci_pkg

//--- source/hci_queue.sv
// Circular FIFO with fill level, ready threshold trigger and flush
`timescale 1ns/10ps

module hci_queue #(
  parameter type entry_t = logic [31:0],
  parameter int unsigned Depth = 8,
  parameter bit ThldOnFree = 1'b0,
  localparam int unsigned DepthWidth = $clog2(Depth + 1),
  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  flush_i,
  input  hci_pkg::thld_t        thld_i,

  input  logic                  push_valid_i,
  output logic                  push_ready_o,
  input  entry_t                push_data_i,

  output logic                  pop_valid_o,
  input  logic                  pop_ready_i,
  output entry_t                pop_data_o,

  output logic [DepthWidth-1:0] depth_o,
  output logic                  thld_trig_o
);
  import hci_pkg::*;

  entry_t                mem_q [Depth];
  logic [PtrWidth-1:0]   wr_ptr_q;
  logic [PtrWidth-1:0]   rd_ptr_q;
  logic [DepthWidth-1:0] count_q;
  logic [DepthWidth-1:0] level;
  thld_t                 thld_eff;
  logic                  push;
  logic                  pop;

  function automatic logic [PtrWidth-1:0] ptr_inc(logic [PtrWidth-1:0] ptr);
    return (ptr == PtrWidth'(Depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign push_ready_o = count_q < DepthWidth'(Depth);  // Low while full
  assign pop_valid_o  = count_q != '0;
  assign pop_data_o   = mem_q[rd_ptr_q];                // Fall-through read

  assign push = push_valid_i & push_ready_o;
  assign pop  = pop_valid_o & pop_ready_i;

  assign depth_o = count_q;

  // Zero threshold behaves as one
  assign thld_eff = (thld_i == '0) ? thld_t'(1) : thld_i;

  // Free space for a write queue, stored entries for a read queue
  assign level       = ThldOnFree ? DepthWidth'(Depth) - count_q : count_q;
  assign thld_trig_o = 32'(level) >= 32'(thld_eff);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      if (push != pop) begin
        count_q <= push ? count_q + 1'b1 : count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

endmodule : hci_queue

//--- source/hci_cmd_assembler.sv
// Command assembler joining two command port dwords into one entry
`timescale 1ns/10ps

module hci_cmd_assembler (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                flush_i,

  input  logic                dword_valid_i,
  output logic                dword_ready_o,
  input  hci_pkg::csr_data_t  dword_i,

  output logic                cmd_valid_o,
  input  logic                cmd_ready_i,
  output hci_pkg::cmd_entry_t cmd_o
);
  import hci_pkg::*;

  logic      phase_q;  // Set while the low dword is held
  csr_data_t hold_q;

  // First dword always fits, second one needs room in the queue
  assign dword_ready_o = phase_q ? cmd_ready_i : 1'b1;

  assign cmd_valid_o = phase_q & dword_valid_i;
  assign cmd_o.lo    = hold_q;
  assign cmd_o.hi    = dword_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      phase_q <= 1'b0;
    end else if (flush_i) begin
      phase_q <= 1'b0;  // Drop half-built command
    end else if (dword_valid_i && dword_ready_o) begin
      phase_q <= ~phase_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (dword_valid_i && !phase_q) begin
      hold_q <= dword_i;
    end
  end

endmodule : hci_cmd_assembler

//--- source/hci_csr_regs.sv
// CPU bus decoder with threshold and queue reset registers,
// command and response port access and queue status
`timescale 1ns/10ps

module hci_csr_regs #(
  parameter int unsigned CmdDepthWidth  = 4,
  parameter int unsigned RespDepthWidth = 4
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,

  input  hci_pkg::csr_req_t         csr_req_i,
  output hci_pkg::csr_rsp_t         csr_rsp_o,

  output hci_pkg::thld_t            cmd_thld_o,
  output hci_pkg::thld_t            resp_thld_o,
  output logic                      cmd_flush_o,
  output logic                      resp_flush_o,

  output logic                      cmd_dword_valid_o,
  input  logic                      cmd_dword_ready_i,
  output hci_pkg::csr_data_t        cmd_dword_o,

  output logic                      resp_pop_o,
  input  logic                      resp_valid_i,
  input  hci_pkg::resp_entry_t      resp_data_i,

  input  logic [CmdDepthWidth-1:0]  cmd_depth_i,
  input  logic [RespDepthWidth-1:0] resp_depth_i
);
  import hci_pkg::*;

  logic      sel_rst;
  logic      sel_thld;
  logic      sel_cmd;
  logic      sel_resp;
  logic      stall_wr;
  logic      wr_acc;
  logic      rd_acc;
  logic      err_d;
  csr_data_t rd_data_d;

  logic      rd_ack_q;
  logic      wr_ack_q;
  logic      err_q;
  csr_data_t rd_data_q;
  logic [1:0] rst_ctrl_q;  // Bit 0 command queue, bit 1 response queue
  thld_t     cmd_thld_q;
  thld_t     resp_thld_q;
  logic      dword_valid_q;
  csr_data_t dword_q;

  assign sel_rst  = csr_req_i.addr == RegResetCtrl;
  assign sel_thld = csr_req_i.addr == RegQueueThld;
  assign sel_cmd  = csr_req_i.addr == RegCommandPort;
  assign sel_resp = csr_req_i.addr == RegResponsePort;

  // Dword still in flight also blocks the next one
  assign stall_wr = csr_req_i.req & csr_req_i.is_wr & sel_cmd &
                    (~cmd_dword_ready_i | dword_valid_q);

  assign wr_acc = csr_req_i.req & csr_req_i.is_wr & ~stall_wr;
  assign rd_acc = csr_req_i.req & ~csr_req_i.is_wr;

  assign resp_pop_o = rd_acc & sel_resp;  // Same-cycle data from the queue

  always_comb begin
    rd_data_d = '0;
    err_d     = 1'b0;
    case (csr_req_i.addr)
      RegResetCtrl: rd_data_d = CsrDataWidth'(rst_ctrl_q);
      RegQueueThld: rd_data_d = CsrDataWidth'({resp_thld_q, cmd_thld_q});
      RegCommandPort: err_d = ~csr_req_i.is_wr;  // Write only
      RegResponsePort: begin
        if (csr_req_i.is_wr || !resp_valid_i) begin
          err_d = 1'b1;  // Read of empty queue returns 0
        end else begin
          rd_data_d = resp_data_i;
        end
      end
      RegQueueStatus: begin
        err_d     = csr_req_i.is_wr;
        rd_data_d = CsrDataWidth'({ThldWidth'(resp_depth_i), ThldWidth'(cmd_depth_i)});
      end
      default: err_d = 1'b1;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ack_q  <= 1'b0;
      wr_ack_q  <= 1'b0;
      err_q     <= 1'b0;
      rd_data_q <= '0;
    end else begin
      rd_ack_q  <= rd_acc;
      wr_ack_q  <= wr_acc;
      err_q     <= (rd_acc | wr_acc) & err_d;
      rd_data_q <= rd_acc ? rd_data_d : '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rst_ctrl_q    <= '0;
      cmd_thld_q    <= thld_t'(1);
      resp_thld_q   <= thld_t'(1);
      dword_valid_q <= 1'b0;
    end else begin
      rst_ctrl_q <= '0;  // Self clearing after one flush cycle
      if (wr_acc && sel_rst) begin
        rst_ctrl_q <= csr_req_i.wdata[1:0];
      end
      if (wr_acc && sel_thld) begin
        cmd_thld_q  <= csr_req_i.wdata[ThldWidth-1:0];
        resp_thld_q <= csr_req_i.wdata[2*ThldWidth-1:ThldWidth];
      end
      dword_valid_q <= wr_acc & sel_cmd;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_acc && sel_cmd) begin
      dword_q <= csr_req_i.wdata;
    end
  end

  assign cmd_thld_o   = cmd_thld_q;
  assign resp_thld_o  = resp_thld_q;
  assign cmd_flush_o  = rst_ctrl_q[0];
  assign resp_flush_o = rst_ctrl_q[1];

  // Dword goes to the assembler along with the ack
  assign cmd_dword_valid_o = dword_valid_q;
  assign cmd_dword_o       = dword_q;

  always_comb begin
    csr_rsp_o.stall_wr = stall_wr;
    csr_rsp_o.rd_ack   = rd_ack_q;
    csr_rsp_o.wr_ack   = wr_ack_q;
    csr_rsp_o.err      = err_q;
    csr_rsp_o.rd_data  = rd_data_q;
  end

endmodule : hci_csr_regs

//--- source/hci_top.sv
// HCI PIO queue block top level with register block, command assembler,
// command queue and response queue
`timescale 1ns/10ps

module hci_top #(
  parameter int unsigned CmdDepth  = 8,
  parameter int unsigned RespDepth = 8
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,

  input  hci_pkg::csr_req_t    csr_req_i,
  output hci_pkg::csr_rsp_t    csr_rsp_o,

  // Command queue, controller side
  output logic                 cmd_valid_o,
  input  logic                 cmd_ready_i,
  output hci_pkg::cmd_entry_t  cmd_o,

  // Response queue, controller side
  input  logic                 resp_valid_i,
  output logic                 resp_ready_o,
  input  hci_pkg::resp_entry_t resp_i,

  output logic                 cmd_thld_trig_o,
  output logic                 resp_thld_trig_o
);
  import hci_pkg::*;

  localparam int unsigned CmdDepthWidth  = $clog2(CmdDepth + 1);
  localparam int unsigned RespDepthWidth = $clog2(RespDepth + 1);

  thld_t       cmd_thld;
  thld_t       resp_thld;
  logic        cmd_flush;
  logic        resp_flush;

  logic        dword_valid;
  logic        dword_ready;
  csr_data_t   dword;

  logic        asm_valid;   // Assembler to command queue
  logic        asm_ready;
  cmd_entry_t  asm_cmd;

  logic        resp_pop;
  logic        resp_avail;
  resp_entry_t resp_data;

  logic [CmdDepthWidth-1:0]  cmd_depth;
  logic [RespDepthWidth-1:0] resp_depth;

  hci_csr_regs #(
    .CmdDepthWidth (CmdDepthWidth),
    .RespDepthWidth(RespDepthWidth)
  ) i_hci_csr_regs (
    .clk_i,
    .rst_ni,
    .csr_req_i,
    .csr_rsp_o,
    .cmd_thld_o       (cmd_thld),
    .resp_thld_o      (resp_thld),
    .cmd_flush_o      (cmd_flush),
    .resp_flush_o     (resp_flush),
    .cmd_dword_valid_o(dword_valid),
    .cmd_dword_ready_i(dword_ready),
    .cmd_dword_o      (dword),
    .resp_pop_o       (resp_pop),
    .resp_valid_i     (resp_avail),
    .resp_data_i      (resp_data),
    .cmd_depth_i      (cmd_depth),
    .resp_depth_i     (resp_depth)
  );

  hci_cmd_assembler i_hci_cmd_assembler (
    .clk_i,
    .rst_ni,
    .flush_i      (cmd_flush),
    .dword_valid_i(dword_valid),
    .dword_ready_o(dword_ready),
    .dword_i      (dword),
    .cmd_valid_o  (asm_valid),
    .cmd_ready_i  (asm_ready),
    .cmd_o        (asm_cmd)
  );

  // Trigger on free entries
  hci_queue #(
    .entry_t   (cmd_entry_t),
    .Depth     (CmdDepth),
    .ThldOnFree(1'b1)
  ) i_hci_cmd_queue (
    .clk_i,
    .rst_ni,
    .flush_i     (cmd_flush),
    .thld_i      (cmd_thld),
    .push_valid_i(asm_valid),
    .push_ready_o(asm_ready),
    .push_data_i (asm_cmd),
    .pop_valid_o (cmd_valid_o),
    .pop_ready_i (cmd_ready_i),
    .pop_data_o  (cmd_o),
    .depth_o     (cmd_depth),
    .thld_trig_o (cmd_thld_trig_o)
  );

  // Trigger on stored entries
  hci_queue #(
    .entry_t   (resp_entry_t),
    .Depth     (RespDepth),
    .ThldOnFree(1'b0)
  ) i_hci_resp_queue (
    .clk_i,
    .rst_ni,
    .flush_i     (resp_flush),
    .thld_i      (resp_thld),
    .push_valid_i(resp_valid_i),
    .push_ready_o(resp_ready_o),
    .push_data_i (resp_i),
    .pop_valid_o (resp_avail),
    .pop_ready_i (resp_pop),
    .pop_data_o  (resp_data),
    .depth_o     (resp_depth),
    .thld_trig_o (resp_thld_trig_o)
  );

endmodule : hci_top

//--- include/tb_hci_checks.svh
// Compare tasks for bus responses, commands and single bits,
// error counters and the random number generator
`ifndef TB_HCI_CHECKS_SVH
`define TB_HCI_CHECKS_SVH

int unsigned check_count = 0;
int unsigned error_count = 0;
logic [31:0] lcg_state   = 32'h5e75_7299;

// Numerical Recipes LCG constants
function automatic logic [31:0] next_random();
  lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
  return lcg_state;
endfunction

function automatic string format_rsp(input csr_rsp_t rsp);
  return $sformatf("stall=%b rd_ack=%b wr_ack=%b err=%b data=%h",
                   rsp.stall_wr, rsp.rd_ack, rsp.wr_ack, rsp.err, rsp.rd_data);
endfunction

task automatic check_rsp(input csr_rsp_t act, input csr_rsp_t exp_rsp);
  check_count++;
  if (act !== exp_rsp) begin
    error_count++;
    $display("FAIL %0t csr_rsp_o expected %s got %s",
             $time, format_rsp(exp_rsp), format_rsp(act));
  end
endtask

task automatic check_cmd(input cmd_entry_t act, input cmd_entry_t exp_cmd);
  check_count++;
  if (act !== exp_cmd) begin
    error_count++;
    $display("FAIL %0t cmd_o expected hi=%h lo=%h got hi=%h lo=%h",
             $time, exp_cmd.hi, exp_cmd.lo, act.hi, act.lo);
  end
endtask

task automatic check_bit(input logic act, input logic exp_bit, input string name);
  check_count++;
  if (act !== exp_bit) begin
    error_count++;
    $display("FAIL %0t %s expected %b got %b", $time, name, exp_bit, act);
  end
endtask

`endif

//--- test/tb_hci_top.sv
// Testbench for the HCI queue block, driven from a trace of bus and controller operations
`timescale 1ns/10ps

module tb_hci_top;
  import hci_pkg::*;

  typedef struct packed {
    logic [7:0]  op;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
  } trace_op_t;

  logic        clk_i;
  logic        rst_ni;
  csr_req_t    csr_req_i;
  csr_rsp_t    csr_rsp_o;
  logic        cmd_valid_o;
  logic        cmd_ready_i;
  cmd_entry_t  cmd_o;
  logic        resp_valid_i;
  logic        resp_ready_o;
  resp_entry_t resp_i;
  logic        cmd_thld_trig_o;
  logic        resp_thld_trig_o;

  int unsigned cycle_count = 0;
  int unsigned cycle_limit = 0;

  `include "tb_hci_checks.svh"

  hci_top #(
    .CmdDepth (4),
    .RespDepth(4)
  ) i_hci_top (.*);

  always #20 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_count++;
    if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
      $display("Timeout: trace not finished after %0d cycles", cycle_count);
      $display("Test failures found");
      $finish;
    end
  end

  // Holds the request until accepted, then checks the ack cycle
  task automatic bus_access(input logic is_wr, input csr_addr_t addr, input csr_data_t data,
                            input logic exp_err);
    csr_req_t req;
    csr_rsp_t exp_rsp;
    logic     stalled;
    req.req          = 1'b1;
    req.is_wr        = is_wr;
    req.addr         = addr;
    req.wdata        = is_wr ? data : '0;
    exp_rsp.stall_wr = 1'b0;
    exp_rsp.rd_ack   = ~is_wr;
    exp_rsp.wr_ack   = is_wr;
    exp_rsp.err      = exp_err;
    exp_rsp.rd_data  = is_wr ? '0 : data;
    @(posedge clk_i);
    csr_req_i <= req;
    do begin
      @(negedge clk_i);
      check_bit(csr_rsp_o.rd_ack | csr_rsp_o.wr_ack, 1'b0, "csr_rsp_o ack");
      stalled = csr_rsp_o.stall_wr;
    end while (stalled);
    @(posedge clk_i);  // Accepted here
    csr_req_i <= '0;
    @(negedge clk_i);
    check_rsp(csr_rsp_o, exp_rsp);
  endtask

  task automatic stall_write(input csr_addr_t addr, input csr_data_t data);
    csr_req_t req;
    req.req   = 1'b1;
    req.is_wr = 1'b1;
    req.addr  = addr;
    req.wdata = data;
    @(posedge clk_i);
    csr_req_i <= req;
    repeat (4) begin
      @(negedge clk_i);
      check_bit(csr_rsp_o.stall_wr, 1'b1, "csr_rsp_o.stall_wr");
      check_bit(csr_rsp_o.wr_ack, 1'b0, "csr_rsp_o.wr_ack");
    end
    @(posedge clk_i);
    csr_req_i <= '0;  // Request withdrawn
  endtask

  task automatic push_response(input resp_entry_t data);
    @(posedge clk_i);
    resp_valid_i <= 1'b1;
    resp_i       <= data;
    do begin
      @(negedge clk_i);
    end while (!resp_ready_o);
    @(posedge clk_i);
    resp_valid_i <= 1'b0;
  endtask

  task automatic pop_command(input cmd_entry_t exp_cmd);
    logic        done;
    logic [31:0] rnd;
    done = 1'b0;
    while (!done) begin
      rnd = next_random();
      @(posedge clk_i);
      cmd_ready_i <= rnd[20];
      @(negedge clk_i);
      if (cmd_valid_o && cmd_ready_i) begin
        check_cmd(cmd_o, exp_cmd);
        done = 1'b1;
      end
    end
    @(posedge clk_i);  // Pop edge
    cmd_ready_i <= 1'b0;
  endtask

  task automatic check_outputs(input logic cmd_trig, input logic resp_trig,
                               input logic resp_rdy);
    @(negedge clk_i);
    check_bit(cmd_thld_trig_o, cmd_trig, "cmd_thld_trig_o");
    check_bit(resp_thld_trig_o, resp_trig, "resp_thld_trig_o");
    check_bit(resp_ready_o, resp_rdy, "resp_ready_o");
  endtask

  task automatic run_op(input trace_op_t t);
    case (t.op)
      "W": bus_access(1'b1, t.a[CsrAddrWidth-1:0], t.b, t.c[0]);
      "R": bus_access(1'b0, t.a[CsrAddrWidth-1:0], t.b, t.c[0]);
      "S": stall_write(t.a[CsrAddrWidth-1:0], t.b);
      "P": push_response(t.a);
      "C": pop_command({t.a, t.b});  // Upper dword first
      "T": check_outputs(t.a[0], t.b[0], t.c[0]);
      "I": repeat (t.a) @(posedge clk_i);
      default: begin
        $display("Unknown trace operation '%c'", t.op);
        error_count++;
      end
    endcase
  endtask

  initial begin
    trace_op_t   ops[$];
    trace_op_t   op;
    string       line;
    int          fd;
    int          n;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    clk_i        = 1'b0;
    rst_ni       = 1'b0;
    csr_req_i    = '0;
    cmd_ready_i  = 1'b0;
    resp_valid_i = 1'b0;
    resp_i       = '0;

    fd = $fopen("test/hci_trace.txt", "r");
    if (fd == 0) begin
      $display("Could not open the trace file test/hci_trace.txt");
      error_count++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        if (n > 1 && line[0] != "#") begin
          a = '0;
          b = '0;
          c = '0;
          n = $sscanf(line.substr(1, line.len() - 1), "%h %h %h", a, b, c);
          op.op = line[0];
          op.a  = a;
          op.b  = b;
          op.c  = c;
          ops.push_back(op);
        end
      end
      $fclose(fd);
    end
    cycle_limit = 20 * ops.size() + 200;

    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    check_rsp(csr_rsp_o, '0);
    check_bit(cmd_valid_o, 1'b0, "cmd_valid_o");

    foreach (ops[i]) begin
      run_op(ops[i]);
    end
    repeat (2) @(posedge clk_i);

    $display("Trace operations: %0d, checks: %0d, errors: %0d",
             ops.size(), check_count, error_count);
    if (error_count == 0 && ops.size() != 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule : tb_hci_top

//--- hci_top.f
+incdir+include
source/hci_pkg.sv
source/hci_queue.sv
source/hci_cmd_assembler.sv
source/hci_csr_regs.sv
source/hci_top.sv
test/tb_hci_top.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_hci_top -f hci_top.f -o sim_hci_top
sim_out=$(./obj_dir/sim_hci_top)
echo "$sim_out"

if echo "$sim_out" | grep -qF 'All tests passed!'; then
  exit 0
fi
echo "Simulation did not pass"
exit 1

//--- test/hci_trace.txt
# W addr data err | R addr data err | S addr data | P resp | C hi lo | I cycles
# T cmd_trig resp_trig resp_ready; all fields hex
T 1 0 1
R 04 00000101 0
R 10 00000000 0
W 08 11110000 0
W 08 22220001 0
R 10 00000001 0
W 08 33330002 0
W 08 44440003 0
W 08 55550004 0
W 08 66660005 0
R 10 00000003 0
C 22220001 11110000
C 44440003 33330002
C 66660005 55550004
P a0000001
P a0000002
R 10 00000200 0
T 1 1 1
R 0c a0000001 0
R 0c a0000002 0
R 0c 00000000 1
R 20 00000000 1
W 0c 12345678 1
R 08 00000000 1
W 10 00000000 1
W 04 00000302 0
R 04 00000302 0
T 1 0 1
P b0000001
P b0000002
T 1 0 1
P b0000003
T 1 1 1
W 08 c0000001 0
W 08 c0000002 0
W 08 c0000003 0
W 08 c0000004 0
T 1 1 1
W 08 c0000005 0
W 08 c0000006 0
T 0 1 1
W 04 00000000 0
T 1 1 1
W 08 c0000007 0
W 08 c0000008 0
R 10 00000304 0
T 0 1 1
P b0000004
T 0 1 0
R 10 00000404 0
W 08 e0000001 0
S 08 e0000002
W 00 00000001 0
R 00 00000000 0
T 1 1 0
W 08 f0000001 0
W 08 f0000002 0
C f0000002 f0000001
W 00 00000002 0
R 10 00000000 0
T 1 0 1
R 0c 00000000 1
P 77777777
R 0c 77777777 0
I 4
